// ==== rtl/board_params.svh ====
`ifndef BOARD_PARAMS_SVH
`define BOARD_PARAMS_SVH

// ------------------------------
// Clock rates
// ------------------------------

`define BOARD_CLK_MHZ      50    // System clock
`define BOARD_VGA_MHZ      25    // Pixel clock of the VGA DAC

// ------------------------------
// Board resources
// ------------------------------

`define BOARD_W_KEY        4
`define BOARD_W_SW         18    // Top switch is the reset
`define BOARD_W_LED        18    // Upper 8 LEDs act as decimal points
`define BOARD_W_DIGIT      8

// ------------------------------
// Dividers, in system clocks
// ------------------------------

`define BOARD_SCAN_DIV     16    // Dwell time of one digit
`define BOARD_SLOW_DIV     1000  // Period of the slow tick
`define BOARD_MIC_SCK_DIV  4     // Half period of mic SCK
`define BOARD_BCLK_DIV     4     // Half period of DAC BCLK

`endif

// ==== rtl/board_pkg.sv ====
`default_nettype none

`include "board_params.svh"

package board_pkg;

    // ------------------------------
    // Display types
    // ------------------------------

    // Segments a..h, a in the MSB, h is the decimal point
    typedef logic [7:0] seg_t;

    // One bit per digit, one-hot while scanning
    typedef logic [`BOARD_W_DIGIT - 1:0] digit_sel_t;

    typedef struct packed
    {
        seg_t       seg;    // Pattern of the selected digit
        digit_sel_t digit;  // Which digit it belongs to
    } scan_t;

    // ------------------------------
    // Board pins
    // ------------------------------

    typedef logic [6:0] hex7_t;  // Active low, bit 0 is segment a

endpackage

`default_nettype wire

// ==== rtl/audio_pkg.sv ====
`default_nettype none

package audio_pkg;

    // ------------------------------
    // Sample words
    // ------------------------------

    typedef logic signed [23:0] mic_sample_t;  // Full microphone word
    typedef logic signed [15:0] pcm_t;         // DAC word

    // ------------------------------
    // I2S pin groups
    // ------------------------------

    typedef struct packed
    {
        logic sck;    // Bit clock to the mic
        logic ws;     // Low selects the left channel
    } mic_i2s_out_t;

    typedef struct packed
    {
        logic mclk;
        logic bclk;
        logic lrclk;  // Low during the left half
        logic sdata;
    } dac_i2s_t;

endpackage

`default_nettype wire

// ==== rtl/i2s_mic_receiver.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "board_params.svh"

module i2s_mic_receiver
(
    input  logic                      clk,
    input  logic                      rst,
    input  logic                      sd,
    output audio_pkg::mic_i2s_out_t   pins,
    output audio_pkg::mic_sample_t    value,
    output logic                      value_valid
);

    import audio_pkg::*;

    localparam int DIV   = `BOARD_MIC_SCK_DIV;
    localparam int W_DIV = $clog2(DIV + 1);

    logic [W_DIV - 1:0] div_cnt;
    logic               div_end;
    logic               sck;
    logic               sck_rise;
    logic               sck_fall;
    logic [5:0]         bit_cnt;   // SCK period inside the frame
    logic               capture;
    logic               commit;    // Last left bit was just taken
    mic_sample_t        shreg;

    // ------------------------------
    // SCK and WS frame
    // ------------------------------

    assign div_end  = (div_cnt == W_DIV'(DIV - 1));
    assign sck_rise = div_end & ~sck;
    assign sck_fall = div_end &  sck;

    // Bits 1..24 after the WS fall carry the left word
    assign capture  = (bit_cnt != 6'd0) && (bit_cnt <= 6'd24);

    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            div_cnt     <= '0;
            sck         <= 1'b0;
            bit_cnt     <= 6'd63;          // First fall of SCK starts a frame
            commit      <= 1'b0;
            value_valid <= 1'b0;
        end
        else
        begin
            div_cnt <= div_end ? '0 : div_cnt + 1'b1;

            if (div_end)
                sck <= ~sck;

            if (sck_fall)
                bit_cnt <= bit_cnt + 6'd1;   // WS follows bit 5

            commit      <= sck_rise && (bit_cnt == 6'd24);
            value_valid <= commit;
        end
    end

    // ------------------------------
    // Data capture
    // ------------------------------

    always_ff @(posedge clk)
    begin
        if (sck_rise && capture)
            shreg <= {shreg[22:0], sd};    // MSB first

        if (commit)
            value <= shreg;
    end

    assign pins = '{sck: sck, ws: bit_cnt[5]};

endmodule

`default_nettype wire

// ==== rtl/i2s_audio_out.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "board_params.svh"

module i2s_audio_out
(
    input  logic                  clk,
    input  logic                  rst,
    input  audio_pkg::pcm_t       sample,
    output audio_pkg::dac_i2s_t   pins
);

    import audio_pkg::*;

    localparam int DIV   = `BOARD_BCLK_DIV;
    localparam int W_DIV = $clog2(DIV + 1);

    logic [W_DIV - 1:0] div_cnt;
    logic               div_end;
    logic               mclk;
    logic               bclk;
    logic               bclk_fall;
    logic [4:0]         slot;      // BCLK period inside the frame
    pcm_t               word;      // Word of the current frame
    pcm_t               shreg;
    logic               sdata;

    // ------------------------------
    // Clocks
    // ------------------------------

    assign div_end   = (div_cnt == W_DIV'(DIV - 1));
    assign bclk_fall = div_end & bclk;

    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            div_cnt <= '0;
            mclk    <= 1'b0;
            bclk    <= 1'b0;
        end
        else
        begin
            mclk    <= ~mclk;              // Half the system clock
            div_cnt <= div_end ? '0 : div_cnt + 1'b1;

            if (div_end)
                bclk <= ~bclk;
        end
    end

    // ------------------------------
    // Serializer
    // ------------------------------

    // Loading at a half boundary puts the MSB one slot late, as I2S wants
    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            slot  <= 5'd31;                // First BCLK fall opens the left half
            word  <= '0;
            shreg <= '0;
            sdata <= 1'b0;
        end
        else if (bclk_fall)
        begin
            slot  <= slot + 5'd1;
            sdata <= shreg[15];

            if (slot == 5'd31)
            begin
                word  <= sample;           // LRCLK falls here
                shreg <= sample;
            end
            else if (slot == 5'd15)
                shreg <= word;             // Same word on the right channel
            else
                shreg <= {shreg[14:0], 1'b0};
        end
    end

    assign pins = '{mclk: mclk, bclk: bclk, lrclk: slot[4], sdata: sdata};

endmodule

`default_nettype wire

// ==== rtl/lab_top.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "board_params.svh"

module lab_top
(
    input  logic                         clk,
    input  logic                         rst,
    input  logic                         slow_tick,
    input  logic [`BOARD_W_KEY - 1:0]    key,
    input  logic [`BOARD_W_SW  - 2:0]    sw,
    input  audio_pkg::mic_sample_t       mic,
    input  logic                         mic_valid,
    output logic [9:0]                   led,
    output board_pkg::scan_t             scan,
    output audio_pkg::pcm_t              sound
);

    import board_pkg::*;
    import audio_pkg::*;

    localparam int SCAN_DIV = `BOARD_SCAN_DIV;
    localparam int W_SCAN   = $clog2(SCAN_DIV + 1);

    mic_sample_t                       mic_q;
    logic [9:0]                        sample_cnt;
    logic                              blink;
    logic [W_SCAN - 1:0]               scan_cnt;
    digit_sel_t                        digit_ring;
    logic [4 * `BOARD_W_DIGIT - 1:0]   nibbles;
    logic [`BOARD_W_DIGIT - 1:0]       dp_bits;
    logic [3:0]                        nibble;
    logic                              dp;

    // Segments a..g for one hex digit
    function automatic logic [6:0] hex_seg(input logic [3:0] n);
        case (n)
            4'h0: return 7'b1111110;
            4'h1: return 7'b0110000;
            4'h2: return 7'b1101101;
            4'h3: return 7'b1111001;
            4'h4: return 7'b0110011;
            4'h5: return 7'b1011011;
            4'h6: return 7'b1011111;
            4'h7: return 7'b1110000;
            4'h8: return 7'b1111111;
            4'h9: return 7'b1111011;
            4'ha: return 7'b1110111;
            4'hb: return 7'b0011111;
            4'hc: return 7'b1001110;
            4'hd: return 7'b0111101;
            4'he: return 7'b1001111;
            default: return 7'b1000111;
        endcase
    endfunction

    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            mic_q      <= '0;
            sample_cnt <= '0;
            blink      <= 1'b0;
            scan_cnt   <= '0;
            digit_ring <= digit_sel_t'(1);   // Digit 0 first
        end
        else
        begin
            if (mic_valid)
            begin
                mic_q      <= mic;
                sample_cnt <= sample_cnt + 10'd1;   // Wraps at 1024
            end

            if (slow_tick)
                blink <= ~blink;

            if (scan_cnt == W_SCAN'(SCAN_DIV - 1))
            begin
                scan_cnt   <= '0;
                digit_ring <= {digit_ring[`BOARD_W_DIGIT - 2:0],
                               digit_ring[`BOARD_W_DIGIT - 1]};
            end
            else
                scan_cnt <= scan_cnt + 1'b1;
        end
    end

    // ------------------------------
    // Digit content
    // ------------------------------

    assign nibbles = {sw[7:0], mic_q};          // Digit i shows nibble i
    assign dp_bits = {blink, 3'b000, key};

    always_comb
    begin
        nibble = 4'h0;
        dp     = 1'b0;
        for (int i = 0; i < `BOARD_W_DIGIT; i++)
            if (digit_ring[i])
            begin
                nibble = nibbles[4 * i +: 4];
                dp     = dp_bits[i];
            end
    end

    assign scan  = '{seg: {hex_seg(nibble), dp}, digit: digit_ring};
    assign led   = sample_cnt;
    assign sound = sw[16] ? pcm_t'(mic_q[23:8]) : '0;   // sw[16] unmutes

endmodule

`default_nettype wire

// ==== rtl/board_top.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "board_params.svh"

module board_top
(
    input  logic                          CLOCK_50,
    input  logic [`BOARD_W_KEY - 1:0]     KEY,        // Active low
    input  logic [`BOARD_W_SW  - 1:0]     SW,
    output logic [`BOARD_W_LED - 1:0]     LEDR,
    output board_pkg::hex7_t              HEX0,
    output board_pkg::hex7_t              HEX1,
    output board_pkg::hex7_t              HEX2,
    output board_pkg::hex7_t              HEX3,
    output board_pkg::hex7_t              HEX4,
    output board_pkg::hex7_t              HEX5,
    output board_pkg::hex7_t              HEX6,
    output board_pkg::hex7_t              HEX7,
    output logic                          VGA_CLK,
    output audio_pkg::mic_i2s_out_t       mic_pins,
    input  logic                          mic_sd,
    output audio_pkg::dac_i2s_t           dac_pins
);

    import board_pkg::*;
    import audio_pkg::*;

    localparam int W_LAB_LED = `BOARD_W_LED - `BOARD_W_DIGIT;
    localparam int SLOW_DIV  = `BOARD_SLOW_DIV;
    localparam int W_SLOW    = $clog2(SLOW_DIV + 1);
    localparam int VGA_DIV   = `BOARD_CLK_MHZ / `BOARD_VGA_MHZ;
    localparam int W_VGA     = $clog2(VGA_DIV + 1);

    logic                           clk;
    logic                           rst;
    logic [W_SLOW - 1:0]            slow_cnt;
    logic                           slow_tick;
    logic [W_VGA - 1:0]             vga_cnt;
    logic [W_LAB_LED - 1:0]         lab_led;
    scan_t                          scan;
    mic_sample_t                    mic;
    logic                           mic_valid;
    pcm_t                           sound;
    hex7_t                          hex_q [`BOARD_W_DIGIT];
    logic [`BOARD_W_DIGIT - 1:0]    dp_q;

    assign clk = CLOCK_50;
    assign rst = SW[`BOARD_W_SW - 1];                 // Top switch resets everything

    // Active-high a..g to the board's active-low bit order
    function automatic hex7_t seg_to_hex(input seg_t seg);
        hex7_t hex;
        for (int j = 0; j < 7; j++)
            hex[j] = ~seg[7 - j];
        return hex;
    endfunction

    // ------------------------------
    // Slow tick and VGA strobe
    // ------------------------------

    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            slow_cnt  <= '0;
            slow_tick <= 1'b0;
            vga_cnt   <= '0;
            VGA_CLK   <= 1'b0;
        end
        else
        begin
            slow_tick <= (slow_cnt == W_SLOW'(SLOW_DIV - 1));
            slow_cnt  <= (slow_cnt == W_SLOW'(SLOW_DIV - 1)) ? '0 : slow_cnt + 1'b1;

            VGA_CLK   <= (vga_cnt == W_VGA'(VGA_DIV - 1));  // One-clock pulse
            vga_cnt   <= (vga_cnt == W_VGA'(VGA_DIV - 1)) ? '0 : vga_cnt + 1'b1;
        end
    end

    // ------------------------------
    // Sticky digit latches
    // ------------------------------

    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            hex_q <= '{default: '1};                  // Blank
            dp_q  <= '0;
        end
        else
            for (int i = 0; i < `BOARD_W_DIGIT; i++)
                if (scan.digit[i])
                begin
                    hex_q[i] <= seg_to_hex(scan.seg);
                    dp_q[i]  <= scan.seg[0];
                end
    end

    assign {HEX7, HEX6, HEX5, HEX4} = {hex_q[7], hex_q[6], hex_q[5], hex_q[4]};
    assign {HEX3, HEX2, HEX1, HEX0} = {hex_q[3], hex_q[2], hex_q[1], hex_q[0]};

    assign LEDR = {dp_q, lab_led};                    // Decimal points on top

    // ------------------------------
    // Lab core and audio
    // ------------------------------

    lab_top lab_top_i
    (
        .clk        (clk),
        .rst        (rst),
        .slow_tick  (slow_tick),
        .key        (~KEY),
        .sw         (SW[`BOARD_W_SW - 2:0]),
        .mic        (mic),
        .mic_valid  (mic_valid),
        .led        (lab_led),
        .scan       (scan),
        .sound      (sound)
    );

    i2s_mic_receiver mic_rx_i
    (
        .clk         (clk),
        .rst         (rst),
        .sd          (mic_sd),
        .pins        (mic_pins),
        .value       (mic),
        .value_valid (mic_valid)
    );

    i2s_audio_out audio_out_i
    (
        .clk     (clk),
        .rst     (rst),
        .sample  (sound),
        .pins    (dac_pins)
    );

endmodule

`default_nettype wire

// ==== verif/board_top_sva.sv ====
`timescale 1ns/10ps
`default_nettype none

module board_top_sva
(
    input logic                    clk,
    input logic                    rst,
    input logic                    vga_clk,
    input board_pkg::digit_sel_t   digit,
    input logic                    sck,
    input logic                    ws,
    input logic                    mclk
);

    // ------------------------------
    // VGA strobe
    // ------------------------------

    vga_single: assert property (@(posedge clk) disable iff (rst) vga_clk |=> !vga_clk)
        else $error("VGA_CLK stayed high for more than one clock");

    vga_period: assert property (@(posedge clk) disable iff (rst) vga_clk |-> ##2 vga_clk)
        else $error("VGA_CLK pulse missing two clocks after the last one");

    // ------------------------------
    // Scan and mic framing
    // ------------------------------

    scan_onehot: assert property (@(posedge clk) disable iff (rst) $onehot(digit))
        else $error("Digit select is not one-hot");

    ws_on_sck_fall: assert property (@(posedge clk) disable iff (rst) $changed(ws) |-> $fell(sck))
        else $error("WS changed away from an SCK falling edge");

    // ------------------------------
    // DAC master clock
    // ------------------------------

    mclk_fall: assert property (@(posedge clk) disable iff (rst) mclk |=> !mclk)
        else $error("MCLK stayed high for more than one clock");

    mclk_rise: assert property (@(posedge clk) disable iff (rst) !mclk |=> mclk)
        else $error("MCLK stayed low for more than one clock");

endmodule

`default_nettype wire

// ==== verif/board_top_tb.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "board_params.svh"

module board_top_tb;

    import board_pkg::*;
    import audio_pkg::*;

    localparam int NUM_FILE   = 8;
    localparam int NUM_RAND   = 4;
    localparam int NUM_TESTS  = NUM_FILE + NUM_RAND;
    localparam int MIC_FRAME  = 128 * `BOARD_MIC_SCK_DIV;   // Clocks per mic frame
    localparam int SCAN_TIME  = `BOARD_W_DIGIT * `BOARD_SCAN_DIV + 2;
    localparam int MAX_CYCLES = (NUM_TESTS + 4) * 3 * MIC_FRAME;

    logic                      clk;
    logic [`BOARD_W_KEY - 1:0] KEY;
    logic [`BOARD_W_SW - 1:0]  SW;
    logic [`BOARD_W_LED - 1:0] LEDR;
    hex7_t                     hex_out [`BOARD_W_DIGIT];
    logic                      VGA_CLK;
    mic_i2s_out_t              mic_pins;
    logic                      mic_sd;
    dac_i2s_t                  dac_pins;

    logic [103:0]              tests [NUM_FILE];
    int                        errors;
    int                        checks;
    int                        cycles;

    // Microphone model state
    mic_sample_t               mic_word;
    int                        mic_tag;
    mic_sample_t               frame_word;
    int                        frame_tag;
    int                        done_tag;
    int                        done_cnt;
    int                        bit_idx;
    logic                      prev_sck;
    logic                      prev_ws;

    // DAC listener state
    logic                      prev_bclk;
    logic                      prev_lr;
    pcm_t                      dac_shift;
    pcm_t                      left_acc;
    pcm_t                      left_word;
    pcm_t                      right_word;
    int                        dac_frames;

    logic [17:0]               r_sw;
    logic [3:0]                r_key;
    mic_sample_t               r_sample;
    logic [103:0]              t;

    board_top board_top_i
    (
        .CLOCK_50 (clk),
        .KEY      (KEY),
        .SW       (SW),
        .LEDR     (LEDR),
        .HEX0     (hex_out[0]),
        .HEX1     (hex_out[1]),
        .HEX2     (hex_out[2]),
        .HEX3     (hex_out[3]),
        .HEX4     (hex_out[4]),
        .HEX5     (hex_out[5]),
        .HEX6     (hex_out[6]),
        .HEX7     (hex_out[7]),
        .VGA_CLK  (VGA_CLK),
        .mic_pins (mic_pins),
        .mic_sd   (mic_sd),
        .dac_pins (dac_pins)
    );

    bind board_top board_top_sva board_top_sva_i
    (
        .clk     (CLOCK_50),
        .rst     (SW[`BOARD_W_SW - 1]),
        .vga_clk (VGA_CLK),
        .digit   (scan.digit),
        .sck     (mic_pins.sck),
        .ws      (mic_pins.ws),
        .mclk    (dac_pins.mclk)
    );

    always #5 clk = ~clk;

    // Active-low seven-segment codes, bit 0 is segment a
    function automatic logic [6:0] hex_code(input logic [3:0] n);
        case (n)
            4'h0: return 7'h40;
            4'h1: return 7'h79;
            4'h2: return 7'h24;
            4'h3: return 7'h30;
            4'h4: return 7'h19;
            4'h5: return 7'h12;
            4'h6: return 7'h02;
            4'h7: return 7'h78;
            4'h8: return 7'h00;
            4'h9: return 7'h10;
            4'ha: return 7'h08;
            4'hb: return 7'h03;
            4'hc: return 7'h46;
            4'hd: return 7'h21;
            4'he: return 7'h06;
            default: return 7'h0e;
        endcase
    endfunction

    task automatic check_value(input string what, input logic [31:0] got,
                               input logic [31:0] exp);
        checks++;
        assert (got === exp)
        else
        begin
            errors++;
            $display("** Error at %0t ns: %s is %h, expected %h", $time, what, got, exp);
        end
    endtask

    // ------------------------------
    // Microphone model
    // ------------------------------

    always @(negedge clk)
    begin
        if (!SW[`BOARD_W_SW - 1])
        begin
            if (prev_sck && !mic_pins.sck)
            begin
                if (prev_ws && !mic_pins.ws)
                begin
                    bit_idx    = 0;           // Left half begins
                    frame_word = mic_word;
                    frame_tag  = mic_tag;
                end
                else
                    bit_idx = bit_idx + 1;

                if (bit_idx >= 1 && bit_idx <= 24)
                    mic_sd = frame_word[24 - bit_idx];   // MSB first
                else
                    mic_sd = 1'b0;

                if (bit_idx == 25)
                begin
                    done_cnt = done_cnt + 1;
                    done_tag = frame_tag;
                    check_value("LEDR[9:0]", 32'(LEDR[9:0]), 32'(done_cnt[9:0]));
                end
            end
            prev_sck = mic_pins.sck;
            prev_ws  = mic_pins.ws;
        end
    end

    // ------------------------------
    // DAC listener
    // ------------------------------

    // The last bit of each word lands in the first slot after the LRCLK edge
    always @(negedge clk)
    begin
        if (!SW[`BOARD_W_SW - 1])
        begin
            if (!prev_bclk && dac_pins.bclk)
            begin
                dac_shift = {dac_shift[14:0], dac_pins.sdata};
                if (prev_lr != dac_pins.lrclk)
                begin
                    if (dac_pins.lrclk)
                        left_acc = dac_shift;        // Left word complete
                    else
                    begin
                        left_word  = left_acc;       // Whole frame complete
                        right_word = dac_shift;
                        dac_frames = dac_frames + 1;
                    end
                end
                prev_lr = dac_pins.lrclk;
            end
            prev_bclk = dac_pins.bclk;
        end
    end

    always @(posedge clk)
    begin
        cycles <= cycles + 1;
        if (cycles >= MAX_CYCLES)
        begin
            $display("Timeout after %0d cycles, the DUT stopped responding", cycles);
            $display("tests failed");
            $finish;
        end
    end

    task automatic run_test(input logic [17:0] sw, input logic [3:0] keys,
                            input mic_sample_t sample, input pcm_t exp_sound,
                            input logic [31:0] exp_nib, input logic [7:0] exp_dp);
        int tag;
        int frames;
        tag      = mic_tag + 1;
        SW       = {1'b0, sw[16:0]};
        KEY      = ~keys;
        mic_word = sample;
        mic_tag  = tag;
        while (done_tag != tag)
            @(negedge clk);
        repeat (SCAN_TIME) @(negedge clk);     // One full scan
        for (int i = 0; i < `BOARD_W_DIGIT; i++)
            check_value($sformatf("HEX%0d", i), 32'(hex_out[i]), 32'(hex_code(exp_nib[4 * i +: 4])));
        check_value("decimal point LEDs", 32'(LEDR[16:10]), 32'(exp_dp[6:0]));
        frames = dac_frames;
        while (dac_frames < frames + 2)
            @(negedge clk);
        check_value("DAC left word", 32'(left_word), 32'(exp_sound));
        check_value("DAC right word", 32'(right_word), 32'(exp_sound));
    endtask

    // ------------------------------
    // Main sequence
    // ------------------------------

    initial
    begin
        clk        = 1'b0;
        SW         = 18'h20000;               // Reset switch on
        KEY        = '1;
        mic_sd     = 1'b0;
        errors     = 0;
        checks     = 0;
        cycles     = 0;
        mic_word   = '0;
        mic_tag    = 0;
        frame_word = '0;
        frame_tag  = 0;
        done_tag   = 0;
        done_cnt   = 0;
        bit_idx    = 0;
        prev_sck   = 1'b0;
        prev_ws    = 1'b1;
        prev_bclk  = 1'b0;
        prev_lr    = 1'b1;
        dac_shift  = '0;
        left_acc   = '0;
        left_word  = '0;
        right_word = '0;
        dac_frames = 0;
        void'($urandom(40683));
        $readmemh("verif/board_tests.txt", tests);

        repeat (4) @(negedge clk);
        for (int i = 0; i < `BOARD_W_DIGIT; i++)
            check_value($sformatf("HEX%0d in reset", i), 32'(hex_out[i]), 32'h7f);
        check_value("LEDR in reset", 32'(LEDR), 32'h0);
        @(negedge clk);
        SW = 18'h00000;

        while (dac_frames < 3)
            @(negedge clk);
        check_value("DAC left word after reset", 32'(left_word), 32'h0);
        check_value("DAC right word after reset", 32'(right_word), 32'h0);

        for (int n = 0; n < NUM_FILE; n++)
        begin
            t = tests[n];
            run_test(t[101:84], t[83:80], t[79:56], t[55:40], t[39:8], t[7:0]);
        end

        for (int n = 0; n < NUM_RAND; n++)
        begin
            r_sw     = 18'($urandom) & 18'h1ffff;
            r_key    = 4'($urandom);
            r_sample = 24'($urandom);
            run_test(r_sw, r_key, r_sample, r_sw[16] ? r_sample[23:8] : 16'h0000,
                     {r_sw[7:0], r_sample}, {4'h0, r_key});
        end

        $display("Checks: %0d, errors: %0d", checks, errors);
        if (errors == 0)
            $display("all tests passed");
        else
            $display("tests failed");
        $finish;
    end

endmodule

`default_nettype wire

// ==== verif/board_tests.txt ====
// Columns: sw(18b)_keys-pressed_mic-sample_sound_digits7..0_decimal-points
// Sound is sample[23:8] when sw[16] is set; digits 7..6 show sw[7:0]
10012_1_123456_1234_12123456_01
000ab_2_abcdef_0000_ababcdef_02
100ff_f_800000_8000_ff800000_0f
10000_0_7fffff_7fff_007fffff_00
0ffc3_4_fedcba_0000_c3fedcba_04
1a55a_8_0f1e2d_0f1e_5a0f1e2d_08
00000_0_000000_0000_00000000_00
13c69_5_9a8b7c_9a8b_699a8b7c_05

// ==== compile.f ====
+incdir+rtl
rtl/board_pkg.sv
rtl/audio_pkg.sv
rtl/i2s_mic_receiver.sv
rtl/i2s_audio_out.sv
rtl/lab_top.sv
rtl/board_top.sv
verif/board_top_sva.sv
verif/board_top_tb.sv

// ==== Makefile ====
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert
LINTFLAGS ?= --lint-only --timing
TOP       ?= board_top_tb
RTL_TOP   ?= board_top
FILELIST  ?= compile.f
OBJ_DIR   ?= obj_dir
PASS_MSG  := all tests passed

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: build
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)
